//--- hdl/fetch_pkg.sv
// fetch front end package with address and instruction types, opcodes and packet layout
package fetch_pkg;

    localparam int XLEN = 32;                   // rv32i datapath width

    typedef logic [XLEN-1:0] addr_t;            // byte address
    typedef logic [XLEN-1:0] inst_t;            // raw instruction word

    localparam addr_t RESET_PC = 32'h0000_0000; // first fetch after reset

    // rv32i major opcodes seen by the predictor
    localparam logic [6:0] OPC_BRANCH = 7'b1100011; // beq/bne/blt/bge/bltu/bgeu
    localparam logic [6:0] OPC_JAL    = 7'b1101111; // pc relative jump
    localparam logic [6:0] OPC_JALR   = 7'b1100111; // register indirect jump

    // output queue toward decode
    localparam int BUF_DEPTH = 2;                              // packets held
    localparam int BUF_PTR_W = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1; // slot index
    localparam int BUF_CNT_W = $clog2(BUF_DEPTH + 1);          // 0..BUF_DEPTH

    // one fetched instruction plus its prediction, 97 bits
    typedef struct packed {
        addr_t pc;                              // address of inst
        inst_t inst;                            // word from imem
        logic  pred_taken;                      // static prediction
        addr_t pred_target;                     // next pc as predicted
    } fetch_pkt_t;

    // wishbone master states
    typedef enum logic [1:0] {
        BUS_IDLE,                               // no cycle open
        BUS_READ,                               // read open, data wanted
        BUS_DROP                                // read open, data stale
    } bus_state_e;

endpackage

//--- hdl/fetch_wb_master.sv
// wishbone classic read master fetching one instruction word per cycle and dropping stale replies
`timescale 1ns/1ps

module fetch_wb_master import fetch_pkg::*; (
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    input  addr_t                fetch_pc_i,   // pc to fetch next
    input  logic                 redirect_i,   // back end flush
    input  logic [BUF_CNT_W-1:0] buf_free_i,   // free slots in output queue
    input  inst_t                wb_dat_i,
    input  logic                 wb_ack_i,
    output logic                 wb_cyc_o,
    output logic                 wb_stb_o,
    output addr_t                wb_adr_o,
    output logic                 rsp_valid_o,  // word accepted this cycle
    output addr_t                rsp_pc_o,
    output inst_t                rsp_inst_o
);

    bus_state_e state_q;
    bus_state_e state_d;
    addr_t      adr_q;                         // address held for the open cycle
    logic       start;

    // only one read in flight, so from idle a single free slot is enough
    // a redirect in the same cycle would latch the old pc, so wait a clock
    assign start = (state_q == BUS_IDLE) && !redirect_i && (buf_free_i != '0);

    always_comb begin
        state_d = state_q;
        case (state_q)
            BUS_IDLE: begin
                if (start) begin
                    state_d = BUS_READ;        // cyc/stb rise next cycle
                end
            end
            BUS_READ: begin
                if (wb_ack_i) begin
                    state_d = BUS_IDLE;        // lower cyc after ack
                end else if (redirect_i) begin
                    state_d = BUS_DROP;        // must still wait for ack
                end
            end
            BUS_DROP: begin
                if (wb_ack_i) begin
                    state_d = BUS_IDLE;        // stale word thrown away
                end
            end
            default: state_d = BUS_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= BUS_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (start) begin
            adr_q <= fetch_pc_i;               // frozen until ack
        end
    end

    assign wb_cyc_o = (state_q != BUS_IDLE);
    assign wb_stb_o = (state_q == BUS_READ) || (state_q == BUS_DROP);
    assign wb_adr_o = adr_q;

    // data passes straight through and a late redirect kills it too
    assign rsp_valid_o = (state_q == BUS_READ) && wb_ack_i && !redirect_i;
    assign rsp_pc_o    = adr_q;
    assign rsp_inst_o  = wb_dat_i;

    // slave may stall, but the request must not move under it
    property p_adr_stable;
        @(posedge clk_i) disable iff (!arst_n_i)
        (wb_stb_o && !wb_ack_i) |=> (wb_stb_o && $stable(wb_adr_o));
    endproperty
    a_adr_stable: assert property (p_adr_stable);

    // slave answers only a request that is up
    a_ack_in_cycle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        wb_ack_i |-> wb_stb_o);

    // queue reports at most its own depth
    a_free_range: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        buf_free_i <= BUF_CNT_W'(BUF_DEPTH));

endmodule

//--- hdl/static_branch_predictor.sv
// static predictor, backward branches and jal taken, everything else falls through
`timescale 1ns/1ps

module static_branch_predictor import fetch_pkg::*; (
    input  addr_t pc_i,            // address of inst_i
    input  inst_t inst_i,          // word just fetched
    input  logic  valid_i,         // inst_i is real this cycle
    output logic  pred_taken_o,
    output addr_t pred_target_o    // pc + 4 when not taken
);

    logic [6:0] opcode;
    addr_t      b_imm;             // sign extended branch offset
    addr_t      j_imm;             // sign extended jal offset
    logic       taken;
    addr_t      target;

    assign opcode = inst_i[6:0];

    // imm[12|10:5|4:1|11], bit 0 always zero
    assign b_imm = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    // imm[20|10:1|11|19:12], bit 0 always zero
    assign j_imm = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

    always_comb begin
        taken  = 1'b0;
        target = pc_i + 32'd4;     // fall through
        case (opcode)
            OPC_BRANCH: begin
                if (b_imm[31]) begin
                    taken  = 1'b1; // backward, likely a loop
                    target = pc_i + b_imm;
                end
            end
            OPC_JAL: begin
                taken  = 1'b1;     // always jumps
                target = pc_i + j_imm;
            end
            OPC_JALR: begin
                // target lives in a register, unknown here
                taken = 1'b0;
            end
            default: begin
                taken = 1'b0;
            end
        endcase
    end

    assign pred_taken_o  = valid_i & taken;
    assign pred_target_o = target;

endmodule

//--- hdl/fetch_pc_gen.sv
// program counter, follows redirect, then prediction, then sequential flow
`timescale 1ns/1ps

module fetch_pc_gen import fetch_pkg::*; (
    input  logic  clk_i,
    input  logic  arst_n_i,
    input  logic  redirect_i,      // back end correction
    input  addr_t redirect_pc_i,
    input  logic  rsp_valid_i,     // a fetch just completed
    input  addr_t rsp_pc_i,        // its address
    input  logic  pred_taken_i,
    input  addr_t pred_target_i,
    output addr_t fetch_pc_o       // next address for the master
);

    addr_t pc_q;
    addr_t pc_d;

    always_comb begin
        pc_d = pc_q;                                   // hold while bus busy
        if (redirect_i) begin
            pc_d = redirect_pc_i;                      // back end wins
        end else if (rsp_valid_i && pred_taken_i) begin
            pc_d = pred_target_i;                      // follow prediction
        end else if (rsp_valid_i) begin
            pc_d = rsp_pc_i + 32'd4;                   // straight line
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= pc_d;
        end
    end

    assign fetch_pc_o = pc_q;

    // redirect targets and predicted offsets both keep 4 byte alignment
    a_pc_aligned: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        fetch_pc_o[1:0] == 2'b00);

endmodule

//--- hdl/fetch_out_buffer.sv
// small circular packet queue toward decode, flushable, reports free slots
`timescale 1ns/1ps

module fetch_out_buffer import fetch_pkg::*; (
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    input  logic                 flush_i,     // drop everything
    input  logic                 wr_i,        // push wr_pkt_i
    input  fetch_pkt_t           wr_pkt_i,
    input  logic                 ready_i,     // decode takes head
    output fetch_pkt_t           pkt_o,       // head of queue
    output logic                 valid_o,
    output logic [BUF_CNT_W-1:0] free_o
);

    fetch_pkt_t           mem [BUF_DEPTH];     // payload, no reset
    logic [BUF_PTR_W-1:0] wr_ptr_q;
    logic [BUF_PTR_W-1:0] rd_ptr_q;
    logic [BUF_CNT_W-1:0] cnt_q;               // entries held
    logic                 do_wr;
    logic                 do_rd;

    function automatic logic [BUF_PTR_W-1:0] ptr_inc(input logic [BUF_PTR_W-1:0] p);
        return (p == BUF_PTR_W'(BUF_DEPTH - 1)) ? '0 : p + 1'b1; // wrap at depth
    endfunction

    assign do_wr = wr_i && !flush_i;                // flush beats a same cycle push
    assign do_rd = valid_o && ready_i && !flush_i;  // pop on handshake

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
        end else if (flush_i) begin
            wr_ptr_q <= '0;                    // empty, restart at slot 0
            rd_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (do_rd) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            case ({do_wr, do_rd})
                2'b10:   cnt_q <= cnt_q + 1'b1;
                2'b01:   cnt_q <= cnt_q - 1'b1;
                default: cnt_q <= cnt_q;       // both or neither
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_wr) begin
            mem[wr_ptr_q] <= wr_pkt_i;
        end
    end

    assign pkt_o   = mem[rd_ptr_q];
    assign valid_o = (cnt_q != '0);
    assign free_o  = BUF_CNT_W'(BUF_DEPTH) - cnt_q;

    // master gates its reads on free_o, so a full queue never sees a push
    a_no_overflow: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (wr_i && !flush_i) |-> (cnt_q != BUF_CNT_W'(BUF_DEPTH)));

endmodule

//--- hdl/fetch_unit_top.sv
// instruction fetch front end, wishbone master, static predictor, pc and decode queue
`timescale 1ns/1ps

module fetch_unit_top import fetch_pkg::*; (
    input  logic       clk_i,
    input  logic       arst_n_i,
    // instruction memory, wishbone classic read only
    output logic       wb_cyc_o,
    output logic       wb_stb_o,
    output addr_t      wb_adr_o,
    input  inst_t      wb_dat_i,
    input  logic       wb_ack_i,
    // decode side
    output fetch_pkt_t pkt_o,
    output logic       pkt_valid_o,
    input  logic       pkt_ready_i,
    // back end redirect
    input  logic       redirect_i,
    input  addr_t      redirect_pc_i
);

    addr_t                fetch_pc;            // pc gen -> master
    logic                 rsp_valid;           // accepted fetch
    addr_t                rsp_pc;
    inst_t                rsp_inst;
    logic                 pred_taken;
    addr_t                pred_target;
    logic [BUF_CNT_W-1:0] buf_free;            // queue -> master
    fetch_pkt_t           wr_pkt;

    fetch_wb_master u_master (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .fetch_pc_i  (fetch_pc),
        .redirect_i  (redirect_i),
        .buf_free_i  (buf_free),
        .wb_dat_i    (wb_dat_i),
        .wb_ack_i    (wb_ack_i),
        .wb_cyc_o    (wb_cyc_o),
        .wb_stb_o    (wb_stb_o),
        .wb_adr_o    (wb_adr_o),
        .rsp_valid_o (rsp_valid),
        .rsp_pc_o    (rsp_pc),
        .rsp_inst_o  (rsp_inst)
    );

    static_branch_predictor u_pred (
        .pc_i          (rsp_pc),
        .inst_i        (rsp_inst),
        .valid_i       (rsp_valid),
        .pred_taken_o  (pred_taken),
        .pred_target_o (pred_target)
    );

    fetch_pc_gen u_pc_gen (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .rsp_valid_i   (rsp_valid),
        .rsp_pc_i      (rsp_pc),
        .pred_taken_i  (pred_taken),
        .pred_target_i (pred_target),
        .fetch_pc_o    (fetch_pc)
    );

    // packet as decode will see it
    assign wr_pkt = '{pc: rsp_pc, inst: rsp_inst, pred_taken: pred_taken,
                      pred_target: pred_target};

    fetch_out_buffer u_buf (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .flush_i  (redirect_i),                // wrong path packets go
        .wr_i     (rsp_valid),
        .wr_pkt_i (wr_pkt),
        .ready_i  (pkt_ready_i),
        .pkt_o    (pkt_o),
        .valid_o  (pkt_valid_o),
        .free_o   (buf_free)
    );

endmodule

//--- testbench/tb_imem_model.sv
// instruction memory model, wishbone classic read slave with random wait states
`timescale 1ns/1ps

module tb_imem_model import fetch_pkg::*; (
    input  logic  clk_i,
    input  logic  arst_n_i,
    input  logic  wb_cyc_i,
    input  logic  wb_stb_i,
    input  addr_t wb_adr_i,
    output inst_t wb_dat_o,
    output logic  wb_ack_o
);

    inst_t       mem [256];                    // 1 KiB, word index adr[9:2]
    integer      seed = 32'he116;              // own stream for wait states
    logic [31:0] rnd;
    logic [1:0]  left;                         // waits still to go this cycle
    logic [1:0]  wait_cnt;
    logic        busy;                         // request seen, counting down

    // preload from the testbench, one word at a time
    task automatic load_word(input addr_t adr, input inst_t word);
        mem[adr[9:2]] = word;
    endtask

    always @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy     <= 1'b0;
            wait_cnt <= 2'd0;
            wb_ack_o <= 1'b0;
            wb_dat_o <= '0;
        end else begin
            wb_ack_o <= 1'b0;                              // ack lasts one cycle
            if (wb_cyc_i && wb_stb_i && !wb_ack_o) begin
                wb_dat_o <= mem[wb_adr_i[9:2]];            // only looked at with ack
                if (!busy) begin
                    rnd = $random(seed);                   // new request, draw latency
                end
                left = busy ? wait_cnt : rnd[1:0];         // 0..3 more, so 1..4 waits
                if (left == 2'd0) begin
                    busy     <= 1'b0;
                    wb_ack_o <= 1'b1;
                end else begin
                    busy     <= 1'b1;
                    wait_cnt <= left - 2'd1;
                end
            end
        end
    end

endmodule

//--- testbench/tb_fetch_unit.sv
// testbench for the fetch front end with directed tests checked against a reference pc walk
`timescale 1ns/1ps

module tb_fetch_unit import fetch_pkg::*; ();

    localparam int N_SEQ = 12;                 // packets awaited per test
    localparam int N_BR  = 16;
    localparam int N_JMP = 12;
    localparam int N_BP  = 24;
    localparam int N_RD  = 30;                 // rough count for the watchdog
    localparam int WDOG_CYCLES = 200 * (N_SEQ + N_BR + N_JMP + N_BP + N_RD);
    localparam inst_t JALR_RA = {12'h000, 5'd1, 3'b000, 5'd0, OPC_JALR}; // jalr x0, 0(x1)

    logic       clk;
    logic       arst_n;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_ack;
    addr_t      wb_adr;
    inst_t      wb_dat;
    fetch_pkt_t pkt;
    logic       pkt_valid;
    logic       pkt_ready;
    logic       redirect;
    addr_t      redirect_pc;

    inst_t  image [256];                       // copy of the imem contents
    string  cur_test;
    integer seed;
    int     errors;
    int     err_base;                          // errors before this test
    int     packets;                           // delivered over all tests
    int     got;                               // delivered in this test
    addr_t  exp_pc;                            // pc of next packet to decode
    addr_t  fetch_exp;                         // address of next bus read
    logic   exp_taken;
    addr_t  exp_tgt;
    logic   prev_cyc;
    logic   prev_ack;
    logic   dropped;                           // open read hit by a redirect

    fetch_unit_top DUT (
        .clk_i         (clk),
        .arst_n_i      (arst_n),
        .wb_cyc_o      (wb_cyc),
        .wb_stb_o      (wb_stb),
        .wb_adr_o      (wb_adr),
        .wb_dat_i      (wb_dat),
        .wb_ack_i      (wb_ack),
        .pkt_o         (pkt),
        .pkt_valid_o   (pkt_valid),
        .pkt_ready_i   (pkt_ready),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc)
    );

    tb_imem_model imem (
        .clk_i    (clk),
        .arst_n_i (arst_n),
        .wb_cyc_i (wb_cyc),
        .wb_stb_i (wb_stb),
        .wb_adr_i (wb_adr),
        .wb_dat_o (wb_dat),
        .wb_ack_o (wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;                 // 4 ns period
    end

    // backward branches and jal count as taken
    function automatic logic is_taken(input inst_t w);
        return (w[6:0] == OPC_JAL) || ((w[6:0] == OPC_BRANCH) && w[31]);
    endfunction

    // successor of pc in the reference walk
    function automatic addr_t next_pc(input addr_t pc, input inst_t w);
        addr_t b_off;
        addr_t j_off;
        b_off = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        j_off = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        if (!is_taken(w)) begin
            return pc + 32'd4;
        end
        return (w[6:0] == OPC_JAL) ? pc + j_off : pc + b_off;
    endfunction

    function automatic inst_t beq_word(input logic [12:0] off);
        return {off[12], off[10:5], 5'd2, 5'd1, 3'b000, off[4:1], off[11], OPC_BRANCH}; // beq
    endfunction

    function automatic inst_t jal_word(input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], 5'd1, OPC_JAL}; // link in x1
    endfunction

    task automatic put_word(input addr_t adr, input inst_t w);
        image[adr[9:2]] = w;
        imem.load_word(adr, w);
    endtask

    task automatic check_addr(input string what, input addr_t exp, input addr_t act);
        if (act !== exp) begin
            $display("error %s %s: expected %h, actual %h", cur_test, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_inst(input string what, input inst_t exp, input inst_t act);
        if (act !== exp) begin
            $display("error %s %s: expected %h, actual %h", cur_test, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_pred(input logic exp_tk, input addr_t exp_tg,
                              input logic act_tk, input addr_t act_tg);
        if ((act_tk !== exp_tk) || (act_tg !== exp_tg)) begin
            $display("error %s prediction: expected %b %h, actual %b %h",
                     cur_test, exp_tk, exp_tg, act_tk, act_tg);
            errors++;
        end
    endtask

    // bus and decode side monitor sampled mid cycle
    always @(negedge clk) begin
        if (!arst_n) begin
            if ((wb_cyc !== 1'b0) || (wb_stb !== 1'b0) || (pkt_valid !== 1'b0)) begin
                $display("error %s reset: expected cyc stb valid 000, actual %b%b%b",
                         cur_test, wb_cyc, wb_stb, pkt_valid);
                errors++;
            end
            exp_pc    = RESET_PC;
            fetch_exp = RESET_PC;
            prev_cyc  = 1'b0;
            prev_ack  = 1'b0;
            dropped   = 1'b0;
            got       = 0;
        end else begin
            if (wb_stb !== wb_cyc) begin                          // raised and lowered together
                $display("error %s strobe: expected %b, actual %b", cur_test, wb_cyc, wb_stb);
                errors++;
            end
            if (prev_cyc && !prev_ack && !wb_cyc) begin
                $display("bus cycle at %h in test %s ended without an ack", wb_adr, cur_test);
                errors++;
            end
            if (prev_ack && wb_cyc) begin
                $display("bus cycle at %h in test %s stayed open after its ack",
                         wb_adr, cur_test);
                errors++;
            end
            if (wb_cyc && !prev_cyc) begin
                dropped = 1'b0;                                   // fresh read
                check_addr("bus address", fetch_exp, wb_adr);
            end
            if (wb_ack && wb_cyc && !dropped && !redirect) begin
                fetch_exp = next_pc(fetch_exp, image[fetch_exp[9:2]]);
            end
            if (pkt_valid && pkt_ready && !redirect) begin        // flush wins over a pop
                exp_taken = is_taken(image[exp_pc[9:2]]);
                exp_tgt   = next_pc(exp_pc, image[exp_pc[9:2]]);
                check_addr("packet pc", exp_pc, pkt.pc);
                check_inst("packet inst", image[exp_pc[9:2]], pkt.inst);
                check_pred(exp_taken, exp_tgt, pkt.pred_taken, pkt.pred_target);
                exp_pc = exp_tgt;
                got++;
            end
            if (redirect) begin
                exp_pc    = redirect_pc;
                fetch_exp = redirect_pc;
                dropped   = wb_cyc;                               // its data is stale
            end
            prev_cyc = wb_cyc;
            prev_ack = wb_ack;
        end
    end

    // reset, fill memory, load one of the small programs, release reset
    task automatic start_test(input string name, input int prog);
        @(posedge clk);
        arst_n    <= 1'b0;
        pkt_ready <= 1'b1;
        redirect  <= 1'b0;
        cur_test = name;
        err_base = errors;
        for (int a = 0; a < 256; a++) begin
            put_word(addr_t'(a * 4), {a[24:0], 7'b0010011});     // addi unique per word
        end
        case (prog)
            1: begin
                put_word(32'h08, beq_word(13'h0008));             // forward so it falls through
                put_word(32'h14, beq_word(13'h1ff0));             // back to 0x04
            end
            2: begin
                put_word(32'h04, jal_word(21'h000040));           // to 0x44
                put_word(32'h44, JALR_RA);
                put_word(32'h48, jal_word(21'h1fffb8));           // back to 0x00
            end
            3: begin
                put_word(32'h04, beq_word(13'h000c));
                put_word(32'h0c, jal_word(21'h000030));           // to 0x3c
                put_word(32'h3c, JALR_RA);
                put_word(32'h40, beq_word(13'h1fc0));             // back to 0x00
            end
            default: begin
            end
        endcase
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
    endtask

    task automatic finish_test(input int n);
        while (got < n) begin
            @(posedge clk);
        end
        packets += got;
        $display("test %s: %0d packets, %0d errors", cur_test, got, errors - err_base);
    endtask

    task automatic straight_line_fetch();
        start_test("sequential", 0);
        finish_test(N_SEQ);
    endtask

    task automatic branch_prediction();
        start_test("branches", 1);
        finish_test(N_BR);
    endtask

    task automatic jump_prediction();
        start_test("jumps", 2);
        finish_test(N_JMP);
    endtask

    task automatic decode_backpressure();
        logic [31:0] r;
        start_test("backpressure", 3);
        while (got < N_BP) begin
            r = $random(seed);
            pkt_ready <= r[0];                                    // held 1..8 cycles
            repeat (int'(r[3:1]) + 1) @(posedge clk);
        end
        pkt_ready <= 1'b1;
        finish_test(N_BP);
    endtask

    task automatic backend_redirect();
        logic [31:0] r;
        start_test("redirect", 3);
        for (int i = 0; i < 6; i++) begin
            r = $random(seed);
            if (i[0]) begin
                @(negedge clk);
                while (!wb_cyc || wb_ack) begin                   // read that stays open
                    @(negedge clk);
                end
                @(posedge clk);
            end else begin
                repeat (int'(r[2:0]) + 1) @(posedge clk);
            end
            redirect_pc <= {22'd0, r[9:2], 2'b00};
            redirect    <= 1'b1;
            @(posedge clk);
            redirect    <= 1'b0;
        end
        finish_test(got + 5);
    endtask

    initial begin
        repeat (WDOG_CYCLES) @(posedge clk);
        $display("timeout in test %s, the DUT stopped delivering packets", cur_test);
        $display("Regression failed");
        $finish;
    end

    initial begin
        arst_n      <= 1'b0;
        pkt_ready   <= 1'b0;
        redirect    <= 1'b0;
        redirect_pc <= RESET_PC;
        seed    = 32'he116;
        errors  = 0;
        packets = 0;
        straight_line_fetch();
        branch_prediction();
        jump_prediction();
        decode_backpressure();
        backend_redirect();
        $display("summary: 5 tests, %0d packets, %0d errors", packets, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- project.f
hdl/fetch_pkg.sv
hdl/fetch_wb_master.sv
hdl/static_branch_predictor.sv
hdl/fetch_pc_gen.sv
hdl/fetch_out_buffer.sv
hdl/fetch_unit_top.sv
testbench/tb_imem_model.sv
testbench/tb_fetch_unit.sv

//--- Makefile
SIM      = verilator
SIMFLAGS = --binary --timing --assert -j 0
TOP      = tb_fetch_unit
FILELIST = project.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Regression failed" $(LOG) || ! grep -q "Regression passed" $(LOG); then \
		exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)
